/* compile.f */
design/ecc_pkg.sv
design/ecc_51_decoder.sv
design/ecc_word_ram.sv
design/mem_arbiter.sv
design/ecc_scrubber.sv
design/ecc_mem_top.sv
verification/ecc_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ECC memory testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ecc_mem_tb -f compile.f \
    && ./obj_dir/Vecc_mem_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/ecc_mem_tb.sv */
module ecc_mem_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int HALF_WORDS     = ecc_pkg::MEM_DEPTH / 2;
    localparam int TRAFFIC_CYCLES = 400;
    localparam int DRAIN_CYCLES   = 8;
    localparam int SWEEP_CYCLES   = ecc_pkg::MEM_DEPTH * (ecc_pkg::SCRUB_INTERVAL + 3);
    localparam int TEST_CYCLES    = RESET_CYCLES + 4 * ecc_pkg::MEM_DEPTH + 6 * HALF_WORDS +
                                    2 * SWEEP_CYCLES + TRAFFIC_CYCLES + 7 * DRAIN_CYCLES;
    localparam int CYCLE_LIMIT    = TEST_CYCLES + 2 * SWEEP_CYCLES;

    typedef struct packed {
        int                  due;                            // cycle where rd_valid is expected.
        ecc_pkg::data_word_t data;
        logic                sbit_err;
        logic                dbit_err;
        logic                check_data;
    } read_record_t;

    logic                  clk;
    logic                  reset;
    ecc_pkg::host_req_t    host_req;
    logic                  ecc_bypass;
    logic                  scrub_enable;
    logic                  rd_valid;
    ecc_pkg::data_word_t   rd_data;
    logic                  rd_sbit_err;
    logic                  rd_dbit_err;
    ecc_pkg::err_count_t   corrected_count;
    ecc_pkg::err_count_t   uncorrectable_count;

    ecc_pkg::data_word_t   exp_data [ecc_pkg::MEM_DEPTH];
    ecc_pkg::inject_mask_t exp_mask [ecc_pkg::MEM_DEPTH];  // corruption still in the stored word.
    read_record_t          expected_q [$];
    logic [31:0]           lfsr_state;
    int                    cycle_count;
    int                    run_cycles;
    int                    error_count;
    int                    read_count;
    int                    single_count;
    int                    op;
    string                 test_name;

    ecc_mem_top i_dut (
        .clk                 (clk),
        .reset               (reset),
        .host_req            (host_req),
        .ecc_bypass          (ecc_bypass),
        .scrub_enable        (scrub_enable),
        .rd_valid            (rd_valid),
        .rd_data             (rd_data),
        .rd_sbit_err         (rd_sbit_err),
        .rd_dbit_err         (rd_dbit_err),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without reaching the end", run_cycles);
            $display("Errors found");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [63:0] random_bits(input int nbits);
        logic [63:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[62:0], feedback};
        end
        return value;
    endfunction

    function automatic int random_pos();
        return int'(random_bits(6)) % ecc_pkg::CODE_WIDTH;
    endfunction

    // two distinct positions when the weight is two.
    function automatic ecc_pkg::inject_mask_t random_mask(input int weight);
        int first;
        int second;
        first  = random_pos();
        second = (first + 1 + random_pos() % (ecc_pkg::CODE_WIDTH - 1)) % ecc_pkg::CODE_WIDTH;
        case (weight)
            0:       return '0;
            1:       return ecc_pkg::inject_mask_t'(1) << first;
            default: return (ecc_pkg::inject_mask_t'(1) << first) |
                            (ecc_pkg::inject_mask_t'(1) << second);
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host port driving and checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_outputs();
        read_record_t rec;
        if (rd_valid) begin
            assert (expected_q.size() > 0 && expected_q[0].due == cycle_count) else begin
                error_count++;
                $display("%s: rd_valid was high at cycle %0d with no host read due",
                         test_name, cycle_count);
            end
            if (expected_q.size() > 0 && expected_q[0].due == cycle_count) begin
                rec = expected_q.pop_front();
                read_count++;
                if (rec.check_data) begin
                    assert (rd_data == rec.data) else begin
                        error_count++;
                        $display("Fail %s: rd_data expected %h actual %h",
                                 test_name, rec.data, rd_data);
                    end
                end
                assert (rd_sbit_err == rec.sbit_err) else begin
                    error_count++;
                    $display("Fail %s: rd_sbit_err expected %b actual %b",
                             test_name, rec.sbit_err, rd_sbit_err);
                end
                assert (rd_dbit_err == rec.dbit_err) else begin
                    error_count++;
                    $display("Fail %s: rd_dbit_err expected %b actual %b",
                             test_name, rec.dbit_err, rd_dbit_err);
                end
            end
        end else begin
            assert (expected_q.size() == 0 || expected_q[0].due > cycle_count) else begin
                error_count++;
                $display("%s: rd_valid stayed low at cycle %0d where a host read was due",
                         test_name, cycle_count);
                rec = expected_q.pop_front();
            end
        end
    endtask

    // outputs are sampled on the falling edge before new inputs go out.
    task automatic step();
        @(negedge clk);
        cycle_count++;
        check_outputs();
        host_req = '0;
    endtask

    task automatic drain(input int cycles);
        repeat (cycles) step();
    endtask

    task automatic write_word(input ecc_pkg::mem_addr_t addr, input ecc_pkg::data_word_t data,
                              input ecc_pkg::inject_mask_t mask);
        step();
        host_req.valid  = 1'b1;
        host_req.write  = 1'b1;
        host_req.addr   = addr;
        host_req.data   = data;
        host_req.inject = mask;
        exp_data[addr]  = data;
        exp_mask[addr]  = mask;
    endtask

    task automatic read_word(input ecc_pkg::mem_addr_t addr);
        read_record_t rec;
        int           weight;
        step();
        host_req.valid = 1'b1;
        host_req.addr  = addr;
        weight         = $countones(exp_mask[addr]);
        rec.due        = cycle_count + 2;
        if (ecc_bypass) begin
            rec.data       = exp_data[addr] ^ exp_mask[addr][ecc_pkg::CODE_WIDTH-1:ecc_pkg::CHECK_WIDTH];
            rec.sbit_err   = 1'b0;
            rec.dbit_err   = 1'b0;
            rec.check_data = 1'b1;
        end else begin
            rec.data       = exp_data[addr];
            rec.sbit_err   = (weight == 1);
            rec.dbit_err   = (weight == 2);
            rec.check_data = (weight != 2);                  // a double error is not corrected.
        end
        expected_q.push_back(rec);
    endtask

    task automatic check_counts(input int corrected, input int uncorrectable);
        assert (corrected_count == ecc_pkg::err_count_t'(corrected)) else begin
            error_count++;
            $display("Fail %s: corrected_count expected %0d actual %0d",
                     test_name, corrected, corrected_count);
        end
        assert (uncorrectable_count == ecc_pkg::err_count_t'(uncorrectable)) else begin
            error_count++;
            $display("Fail %s: uncorrectable_count expected %0d actual %0d",
                     test_name, uncorrectable, uncorrectable_count);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        host_req     = '0;
        ecc_bypass   = 1'b0;
        scrub_enable = 1'b0;
        lfsr_state   = 32'he502_9778;
        cycle_count  = 0;
        run_cycles   = 0;
        error_count  = 0;
        read_count   = 0;
        single_count = 0;
        test_name    = "reset";
        repeat (RESET_CYCLES) step();
        reset = 1'b0;
        check_counts(0, 0);

        test_name = "zero_mask";
        for (int i = 0; i < ecc_pkg::MEM_DEPTH; i++) begin
            write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)), '0);
        end
        for (int i = 0; i < ecc_pkg::MEM_DEPTH; i++) begin
            read_word(ecc_pkg::mem_addr_t'(random_bits(6)));
        end
        drain(DRAIN_CYCLES);

        test_name = "single_bit";
        for (int i = 0; i < HALF_WORDS; i++) begin
            write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)),
                       (i < ecc_pkg::CHECK_WIDTH) ? ecc_pkg::inject_mask_t'(1) << i
                                                  : random_mask(1)); // every check bit once.
        end
        for (int i = 0; i < HALF_WORDS; i++) begin
            read_word(ecc_pkg::mem_addr_t'(i));
        end
        drain(DRAIN_CYCLES);

        test_name = "double_bit";
        for (int i = HALF_WORDS; i < ecc_pkg::MEM_DEPTH; i++) begin
            write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)),
                       random_mask(2));
        end
        for (int i = HALF_WORDS; i < ecc_pkg::MEM_DEPTH; i++) begin
            read_word(ecc_pkg::mem_addr_t'(i));
        end
        drain(DRAIN_CYCLES);

        test_name = "bypass";
        for (int i = 0; i < HALF_WORDS; i++) begin
            write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)),
                       random_mask(int'(random_bits(2)) % 3));
        end
        ecc_bypass = 1'b1;
        for (int i = 0; i < HALF_WORDS; i++) begin
            read_word(ecc_pkg::mem_addr_t'(i));
        end
        drain(DRAIN_CYCLES);
        ecc_bypass = 1'b0;

        test_name = "scrub_sweep";
        for (int i = 0; i < ecc_pkg::MEM_DEPTH; i++) begin
            if (random_bits(1) == 64'd1) begin
                single_count++;
                write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)),
                           random_mask(1));
            end else begin
                write_word(ecc_pkg::mem_addr_t'(i), ecc_pkg::data_word_t'(random_bits(51)), '0);
            end
        end
        scrub_enable = 1'b1;
        drain(2 * SWEEP_CYCLES);
        scrub_enable = 1'b0;
        drain(DRAIN_CYCLES);                                 // lets a pending write-back finish.
        for (int i = 0; i < ecc_pkg::MEM_DEPTH; i++) begin
            exp_mask[i] = '0;
        end
        for (int i = 0; i < ecc_pkg::MEM_DEPTH; i++) begin
            read_word(ecc_pkg::mem_addr_t'(i));
        end
        drain(DRAIN_CYCLES);
        check_counts(single_count, 0);

        test_name    = "mixed_traffic";
        scrub_enable = 1'b1;
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
            op = int'(random_bits(2));
            case (op)
                0:       step();                             // idle cycle for the scrubber.
                1:       write_word(ecc_pkg::mem_addr_t'(random_bits(6)),
                                    ecc_pkg::data_word_t'(random_bits(51)), '0);
                default: read_word(ecc_pkg::mem_addr_t'(random_bits(6)));
            endcase
        end
        scrub_enable = 1'b0;
        drain(DRAIN_CYCLES);
        check_counts(single_count, 0);

        assert (expected_q.size() == 0) else begin
            error_count++;
            $display("%0d host reads never returned rd_valid", expected_q.size());
        end
        $display("Host reads checked: %0d, errors: %0d", read_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* design/ecc_mem_top.sv */
module ecc_mem_top (
    input  logic                clk,
    input  logic                reset,
    input  ecc_pkg::host_req_t  host_req,
    input  logic                ecc_bypass,
    input  logic                scrub_enable,
    output logic                rd_valid,
    output ecc_pkg::data_word_t rd_data,
    output logic                rd_sbit_err,
    output logic                rd_dbit_err,
    output ecc_pkg::err_count_t corrected_count,
    output ecc_pkg::err_count_t uncorrectable_count
);

    ecc_pkg::scrub_req_t   scrub_req;
    logic                  scrub_grant;
    ecc_pkg::mem_cmd_t     cmd;
    logic                  host_wr;
    ecc_pkg::mem_addr_t    host_wr_addr;
    ecc_pkg::codeword_t    rd_codeword;
    ecc_pkg::decode_t      decoded;
    ecc_pkg::read_result_t host_rd;
    ecc_pkg::read_result_t scrub_rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mem_arbiter i_arbiter (
        .clk          (clk),
        .reset        (reset),
        .host_req     (host_req),
        .scrub_req    (scrub_req),
        .scrub_grant  (scrub_grant),
        .cmd          (cmd),
        .host_wr      (host_wr),
        .host_wr_addr (host_wr_addr),
        .decoded      (decoded),
        .host_rd      (host_rd),
        .scrub_rd     (scrub_rd)
    );

    ecc_word_ram i_ram (
        .clk         (clk),
        .cmd         (cmd),
        .rd_codeword (rd_codeword)
    );

    ecc_51_decoder i_decoder (
        .codeword (rd_codeword),
        .bypass   (ecc_bypass),
        .data     (decoded.data),
        .sbit_err (decoded.sbit_err),
        .dbit_err (decoded.dbit_err)
    );

    ecc_scrubber i_scrubber (
        .clk                 (clk),
        .reset               (reset),
        .scrub_enable        (scrub_enable),
        .bypass              (ecc_bypass),
        .scrub_req           (scrub_req),
        .scrub_grant         (scrub_grant),
        .scrub_rd            (scrub_rd),
        .host_wr             (host_wr),
        .host_wr_addr        (host_wr_addr),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host read output register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid    <= 1'b0;
            rd_sbit_err <= 1'b0;
            rd_dbit_err <= 1'b0;
        end else begin
            rd_valid    <= host_rd.valid;
            rd_sbit_err <= host_rd.valid && host_rd.sbit_err; // flags only travel with rd_valid.
            rd_dbit_err <= host_rd.valid && host_rd.dbit_err;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd.valid) begin
            rd_data <= host_rd.data;                         // held until the next host read.
        end
    end

endmodule

/* design/ecc_scrubber.sv */
module ecc_scrubber (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  scrub_enable,
    input  logic                  bypass,
    output ecc_pkg::scrub_req_t   scrub_req,
    input  logic                  scrub_grant,
    input  ecc_pkg::read_result_t scrub_rd,
    input  logic                  host_wr,
    input  ecc_pkg::mem_addr_t    host_wr_addr,
    output ecc_pkg::err_count_t   corrected_count,
    output ecc_pkg::err_count_t   uncorrectable_count
);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_READ,
        ST_RESULT,
        ST_WRITE_BACK
    } state_t;

    state_t              state;
    ecc_pkg::interval_t  idle_count;
    ecc_pkg::mem_addr_t  scrub_addr;
    ecc_pkg::data_word_t wb_data;
    logic                host_hit;
    logic                fix_seen;
    logic                bad_seen;

    function automatic ecc_pkg::err_count_t sat_inc(input ecc_pkg::err_count_t count);
        return (count == '1) ? count : count + 1'b1;
    endfunction

    assign host_hit = host_wr && (host_wr_addr == scrub_addr); // newer data, drop the fix.
    assign fix_seen = scrub_rd.valid && scrub_rd.sbit_err && !bypass;
    assign bad_seen = scrub_rd.valid && scrub_rd.dbit_err && !bypass;

    always_comb begin
        scrub_req.valid = (state == ST_READ) || (state == ST_WRITE_BACK);
        scrub_req.write = (state == ST_WRITE_BACK);
        scrub_req.addr  = scrub_addr;
        scrub_req.data  = wb_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sweep FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= ST_WAIT;
            idle_count          <= '0;
            scrub_addr          <= '0;
            corrected_count     <= '0;
            uncorrectable_count <= '0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (!scrub_enable) begin
                        idle_count <= '0;
                    end else if (idle_count == ecc_pkg::interval_t'(ecc_pkg::SCRUB_INTERVAL - 1)) begin
                        idle_count <= '0;
                        state      <= ST_READ;
                    end else begin
                        idle_count <= idle_count + 1'b1;
                    end
                end
                ST_READ: begin
                    if (scrub_grant) begin
                        state <= ST_RESULT;                  // held until the host is quiet.
                    end
                end
                ST_RESULT: begin
                    if (fix_seen && !host_hit) begin
                        state <= ST_WRITE_BACK;
                    end else begin
                        scrub_addr <= scrub_addr + 1'b1;
                        state      <= ST_WAIT;
                    end
                    if (bad_seen) begin
                        uncorrectable_count <= sat_inc(uncorrectable_count);
                    end
                end
                ST_WRITE_BACK: begin
                    if (host_hit) begin
                        scrub_addr <= scrub_addr + 1'b1;
                        state      <= ST_WAIT;
                    end else if (scrub_grant) begin
                        corrected_count <= sat_inc(corrected_count);
                        scrub_addr      <= scrub_addr + 1'b1;
                        state           <= ST_WAIT;
                    end
                end
                default: begin
                    state <= ST_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_RESULT && fix_seen) begin
            wb_data <= scrub_rd.data;                        // corrected word for the write-back.
        end
    end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  ecc_pkg::host_req_t    host_req,
    input  ecc_pkg::scrub_req_t   scrub_req,
    output logic                  scrub_grant,
    output ecc_pkg::mem_cmd_t     cmd,
    output logic                  host_wr,
    output ecc_pkg::mem_addr_t    host_wr_addr,
    input  ecc_pkg::decode_t      decoded,
    output ecc_pkg::read_result_t host_rd,
    output ecc_pkg::read_result_t scrub_rd
);

    ecc_pkg::data_word_t wr_data;
    ecc_pkg::codeword_t  clean_word;
    logic                rd_pending;
    logic                rd_owner_host;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port ownership and command.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign scrub_grant  = scrub_req.valid && !host_req.valid; // the host is never refused.
    assign host_wr      = host_req.valid && host_req.write;
    assign host_wr_addr = host_req.addr;

    assign wr_data          = host_req.valid ? host_req.data : scrub_req.data;
    assign clean_word.data  = wr_data;
    assign clean_word.check = ecc_pkg::ecc_encode(wr_data);

    always_comb begin
        cmd = '0;
        if (host_req.valid) begin
            cmd.valid    = 1'b1;
            cmd.write    = host_req.write;
            cmd.addr     = host_req.addr;
            cmd.codeword = clean_word ^ host_req.inject;     // deliberate corruption on writes.
        end else if (scrub_grant) begin
            cmd.valid    = 1'b1;
            cmd.write    = scrub_req.write;
            cmd.addr     = scrub_req.addr;
            cmd.codeword = clean_word;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return routing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending    <= 1'b0;
            rd_owner_host <= 1'b0;
        end else begin
            rd_pending    <= cmd.valid && !cmd.write;
            rd_owner_host <= host_req.valid;                 // tag lines up with rd_codeword.
        end
    end

    always_comb begin
        host_rd.valid    = rd_pending && rd_owner_host;
        host_rd.data     = decoded.data;
        host_rd.sbit_err = decoded.sbit_err;
        host_rd.dbit_err = decoded.dbit_err;
        scrub_rd         = host_rd;
        scrub_rd.valid   = rd_pending && !rd_owner_host;
    end

endmodule

/* design/ecc_word_ram.sv */
module ecc_word_ram (
    input  logic               clk,
    input  ecc_pkg::mem_cmd_t  cmd,
    output ecc_pkg::codeword_t rd_codeword
);

    ecc_pkg::codeword_t mem [ecc_pkg::MEM_DEPTH];

    // single port, so a command is either a write or a read.
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            if (cmd.write) begin
                mem[cmd.addr] <= cmd.codeword;
            end else begin
                rd_codeword <= mem[cmd.addr];                // data is back one cycle later.
            end
        end
    end

endmodule

/* design/ecc_51_decoder.sv */
module ecc_51_decoder (
    input  ecc_pkg::codeword_t  codeword,
    input  logic                bypass,
    output ecc_pkg::data_word_t data,
    output logic                sbit_err,
    output logic                dbit_err
);

    ecc_pkg::check_word_t syndrome;
    ecc_pkg::data_word_t  flip_mask;
    logic                 data_hit;
    logic                 check_hit;
    logic                 no_error;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Syndrome and correction mask.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign syndrome = codeword.check ^ ecc_pkg::ecc_encode(codeword.data);

    // each data column code is the encoding of a one-hot word.
    always_comb begin
        flip_mask = '0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (syndrome == ecc_pkg::ecc_encode(ecc_pkg::data_word_t'(1) << i)) begin
                flip_mask[i] = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classification.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign data_hit  = |flip_mask;
    assign check_hit = $onehot(syndrome);                     // a flipped check bit only.
    assign no_error  = (syndrome == '0);

    always_comb begin
        if (bypass) begin
            data     = codeword.data;
            sbit_err = 1'b0;
            dbit_err = 1'b0;
        end else begin
            data     = codeword.data ^ flip_mask;
            sbit_err = data_hit || check_hit;
            dbit_err = !no_error && !data_hit && !check_hit; // any unmatched syndrome.
        end
    end

endmodule

/* design/ecc_pkg.sv */
package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and memory shape.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_WIDTH     = 51;
    localparam int CHECK_WIDTH    = 7;
    localparam int CODE_WIDTH     = DATA_WIDTH + CHECK_WIDTH;
    localparam int ADDR_WIDTH     = 6;
    localparam int MEM_DEPTH      = 64;
    localparam int COUNT_WIDTH    = 16;
    localparam int SCRUB_INTERVAL = 4;                       // idle cycles between scrub reads.
    localparam int INTERVAL_WIDTH = $clog2(SCRUB_INTERVAL + 1);

    typedef logic [DATA_WIDTH-1:0]     data_word_t;
    typedef logic [CHECK_WIDTH-1:0]    check_word_t;
    typedef logic [CODE_WIDTH-1:0]     inject_mask_t;
    typedef logic [ADDR_WIDTH-1:0]     mem_addr_t;
    typedef logic [COUNT_WIDTH-1:0]    err_count_t;
    typedef logic [INTERVAL_WIDTH-1:0] interval_t;

    typedef struct packed {
        data_word_t  data;                                   // upper 51 bits of the codeword.
        check_word_t check;
    } codeword_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and result bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic         valid;
        logic         write;
        mem_addr_t    addr;
        data_word_t   data;
        inject_mask_t inject;                                // xored into the stored codeword.
    } host_req_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        mem_addr_t  addr;
        data_word_t data;
    } scrub_req_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        mem_addr_t addr;
        codeword_t codeword;
    } mem_cmd_t;

    typedef struct packed {
        data_word_t data;
        logic       sbit_err;
        logic       dbit_err;
    } decode_t;

    typedef struct packed {
        logic       valid;
        data_word_t data;
        logic       sbit_err;
        logic       dbit_err;
    } read_result_t;

    // check bits of a data word, shared by the write path and the decoder.
    function automatic check_word_t ecc_encode(input data_word_t d);
        check_word_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^
               d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32] ^
               d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48] ^ d[50];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^
               d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32] ^
               d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^
               d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32] ^
               d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]) ^ (^d[50:49]);
        p[4] = (^d[25:11]) ^ (^d[50:41]);
        p[5] = ^d[50:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^
               d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32] ^
               d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47] ^ d[50];
        return p;
    endfunction

endpackage
